/* logic/lc3b_rs_pkg.sv */
`default_nettype none

package lc3b_rs_pkg;

	// datapath and tag widths.
	localparam int word_width = 16;
	localparam int tag_width = 3;

	// number of ALU reservation stations.
	localparam int num_rs = 3;

	typedef logic [word_width-1:0] lc3b_word;

	// tag 0 marks an operand that is already present.
	typedef logic [tag_width-1:0] rs_tag;

	// instruction bits 15 to 12.
	typedef enum logic [3:0] {
		op_br   = 4'b0000,
		op_add  = 4'b0001,
		op_ldb  = 4'b0010,
		op_stb  = 4'b0011,
		op_jsr  = 4'b0100,
		op_and  = 4'b0101,
		op_ldr  = 4'b0110,
		op_str  = 4'b0111,
		op_rti  = 4'b1000,
		op_not  = 4'b1001,
		op_ldi  = 4'b1010,
		op_sti  = 4'b1011,
		op_jmp  = 4'b1100,
		op_shf  = 4'b1101,
		op_lea  = 4'b1110,
		op_trap = 4'b1111
	} lc3b_opcode;

	// operations the cluster ALU can perform.
	typedef enum logic [2:0] {
		alu_add,
		alu_and,
		alu_not,
		alu_sll,
		alu_srl,
		alu_sra,
		alu_pass
	} lc3b_aluop;

endpackage : lc3b_rs_pkg

`default_nettype wire

/* logic/alu_decode.sv */
`timescale 1ns/10ps
`default_nettype none

module alu_decode
	import lc3b_rs_pkg::*;
(
	input wire lc3b_word instr,
	output lc3b_aluop aluop
);

	lc3b_opcode opcode;

	assign opcode = lc3b_opcode'(instr[15:12]);

	always_comb begin
		case (opcode)
			op_add: aluop = alu_add;
			op_and: aluop = alu_and;
			op_not: aluop = alu_not;
			op_shf: begin
				// bit 4 picks the direction, bit 5 arithmetic.
				if (!instr[4])
					aluop = alu_sll;
				else if (instr[5])
					aluop = alu_sra;
				else
					aluop = alu_srl;
			end
			default: aluop = alu_pass;
		endcase
	end

endmodule : alu_decode

`default_nettype wire

/* logic/alu.sv */
`timescale 1ns/10ps
`default_nettype none

module alu
	import lc3b_rs_pkg::*;
(
	input wire lc3b_aluop aluop,
	input wire lc3b_word a,
	input wire lc3b_word b,
	output lc3b_word f
);

	// shift amount is the low nibble of b.
	logic [3:0] shamt;

	assign shamt = b[3:0];

	always_comb begin
		case (aluop)
			alu_add: f = a + b;
			alu_and: f = a & b;
			alu_not: f = ~a;
			alu_sll: f = a << shamt;
			alu_srl: f = a >> shamt;
			alu_sra: f = lc3b_word'($signed(a) >>> shamt);
			default: f = a;
		endcase
	end

endmodule : alu

`default_nettype wire

/* logic/alu_res_station.sv */
`timescale 1ns/10ps
`default_nettype none

module alu_res_station
	import lc3b_rs_pkg::*;
(
	input wire logic clk,
	input wire logic rst,
	input wire logic flush,
	input wire logic load,
	input wire lc3b_word instr,
	input wire lc3b_word vj,
	input wire lc3b_word vk,
	input wire rs_tag qj,
	input wire rs_tag qk,
	input wire rs_tag dest,
	input wire logic cdb_valid,
	input wire rs_tag cdb_tag,
	input wire lc3b_word cdb_data,
	input wire logic grant,
	output logic busy,
	output logic ready,
	output lc3b_aluop aluop,
	output lc3b_word op_a,
	output lc3b_word op_b,
	output rs_tag dest_out
);

	logic busy_q;
	lc3b_word instr_q;
	lc3b_word vj_q;
	lc3b_word vk_q;
	rs_tag qj_q;
	rs_tag qk_q;
	rs_tag dest_q;

	// operand source is the issue port on load, else the stored copy.
	lc3b_word sel_vj;
	lc3b_word sel_vk;
	rs_tag sel_qj;
	rs_tag sel_qk;
	logic hit_j;
	logic hit_k;
	logic update;

	assign sel_vj = load ? vj : vj_q;
	assign sel_vk = load ? vk : vk_q;
	assign sel_qj = load ? qj : qj_q;
	assign sel_qk = load ? qk : qk_q;

	// same snoop rule at issue and while waiting.
	assign hit_j = cdb_valid && (sel_qj != '0) && (sel_qj == cdb_tag);
	assign hit_k = cdb_valid && (sel_qk != '0) && (sel_qk == cdb_tag);

	assign update = load || busy_q;

	always_ff @(posedge clk) begin
		if (rst || flush) begin
			busy_q <= 1'b0;
			qj_q <= '0;
			qk_q <= '0;
		end else begin
			if (load)
				busy_q <= 1'b1;
			else if (grant)
				busy_q <= 1'b0;
			if (update) begin
				qj_q <= hit_j ? '0 : sel_qj;
				qk_q <= hit_k ? '0 : sel_qk;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			instr_q <= instr;
			dest_q <= dest;
		end
		if (update) begin
			vj_q <= hit_j ? cdb_data : sel_vj;
			vk_q <= hit_k ? cdb_data : sel_vk;
		end
	end

	assign busy = busy_q;
	assign ready = busy_q && (qj_q == '0) && (qk_q == '0);

	alu_decode alu_decode_i (
		.instr(instr_q),
		.aluop(aluop)
	);

	assign op_a = vj_q;
	assign op_b = vk_q;
	assign dest_out = dest_q;

endmodule : alu_res_station

`default_nettype wire

/* logic/rs_scheduler.sv */
`timescale 1ns/10ps
`default_nettype none

module rs_scheduler
	import lc3b_rs_pkg::*;
(
	input wire logic clk,
	input wire logic rst,
	input wire logic flush,
	input wire logic issue_valid,
	input wire logic [num_rs-1:0] busy,
	input wire logic [num_rs-1:0] ready,
	input wire logic ext_valid,
	input wire rs_tag ext_tag,
	input wire lc3b_word ext_data,
	input wire lc3b_word alu_result,
	input wire rs_tag [num_rs-1:0] rs_dest,
	output logic [num_rs-1:0] issue_sel,
	output logic [num_rs-1:0] grant,
	output logic issue_ready,
	output logic cdb_valid,
	output rs_tag cdb_tag,
	output lc3b_word cdb_data
);

	rs_tag grant_tag;

	// isolates the lowest set bit, so lowest index wins.
	function automatic logic [num_rs-1:0] lowest_one(input logic [num_rs-1:0] v);
		return v & (~v + 1'b1);
	endfunction

	assign issue_ready = ~&busy;
	assign issue_sel = issue_valid ? lowest_one(~busy) : '0;

	// external results own the CDB for their cycle.
	assign grant = ext_valid ? '0 : lowest_one(ready);

	always_comb begin
		grant_tag = '0;
		for (int i = 0; i < num_rs; i++) begin
			if (grant[i])
				grant_tag = grant_tag | rs_dest[i];
		end
	end

	always_ff @(posedge clk) begin
		if (rst || flush)
			cdb_valid <= 1'b0;
		else
			cdb_valid <= ext_valid || (|grant);
	end

	always_ff @(posedge clk) begin
		if (ext_valid) begin
			cdb_tag <= ext_tag;
			cdb_data <= ext_data;
		end else begin
			cdb_tag <= grant_tag;
			cdb_data <= alu_result;
		end
	end

endmodule : rs_scheduler

`default_nettype wire

/* logic/alu_cluster.sv */
`timescale 1ns/10ps
`default_nettype none

module alu_cluster
	import lc3b_rs_pkg::*;
(
	input wire logic clk,
	input wire logic rst,
	input wire logic flush,
	input wire logic issue_valid,
	input wire lc3b_word issue_instr,
	input wire lc3b_word issue_vj,
	input wire lc3b_word issue_vk,
	input wire rs_tag issue_qj,
	input wire rs_tag issue_qk,
	input wire rs_tag issue_dest,
	input wire logic ext_valid,
	input wire rs_tag ext_tag,
	input wire lc3b_word ext_data,
	output logic issue_ready,
	output logic cdb_valid,
	output rs_tag cdb_tag,
	output lc3b_word cdb_data
);

	localparam int op_bits = $bits(lc3b_aluop);

	logic [num_rs-1:0] busy;
	logic [num_rs-1:0] ready;
	logic [num_rs-1:0] issue_sel;
	logic [num_rs-1:0] grant;
	lc3b_aluop rs_aluop [num_rs];
	lc3b_word rs_op_a [num_rs];
	lc3b_word rs_op_b [num_rs];
	rs_tag [num_rs-1:0] rs_dest;

	// one-hot and-or chains selecting the granted station.
	logic [num_rs:0][op_bits-1:0] aluop_chain;
	lc3b_word [num_rs:0] a_chain;
	lc3b_word [num_rs:0] b_chain;
	lc3b_word alu_result;

	assign aluop_chain[0] = '0;
	assign a_chain[0] = '0;
	assign b_chain[0] = '0;

	for (genvar i = 0; i < num_rs; i++) begin : g_rs
		alu_res_station alu_res_station_i (
			.clk(clk),
			.rst(rst),
			.flush(flush),
			.load(issue_sel[i]),
			.instr(issue_instr),
			.vj(issue_vj),
			.vk(issue_vk),
			.qj(issue_qj),
			.qk(issue_qk),
			.dest(issue_dest),
			.cdb_valid(cdb_valid),
			.cdb_tag(cdb_tag),
			.cdb_data(cdb_data),
			.grant(grant[i]),
			.busy(busy[i]),
			.ready(ready[i]),
			.aluop(rs_aluop[i]),
			.op_a(rs_op_a[i]),
			.op_b(rs_op_b[i]),
			.dest_out(rs_dest[i])
		);

		assign aluop_chain[i+1] = aluop_chain[i] | (rs_aluop[i] & {op_bits{grant[i]}});
		assign a_chain[i+1] = a_chain[i] | (rs_op_a[i] & {word_width{grant[i]}});
		assign b_chain[i+1] = b_chain[i] | (rs_op_b[i] & {word_width{grant[i]}});
	end

	alu alu_i (
		.aluop(lc3b_aluop'(aluop_chain[num_rs])),
		.a(a_chain[num_rs]),
		.b(b_chain[num_rs]),
		.f(alu_result)
	);

	rs_scheduler rs_scheduler_i (
		.clk(clk),
		.rst(rst),
		.flush(flush),
		.issue_valid(issue_valid),
		.busy(busy),
		.ready(ready),
		.ext_valid(ext_valid),
		.ext_tag(ext_tag),
		.ext_data(ext_data),
		.alu_result(alu_result),
		.rs_dest(rs_dest),
		.issue_sel(issue_sel),
		.grant(grant),
		.issue_ready(issue_ready),
		.cdb_valid(cdb_valid),
		.cdb_tag(cdb_tag),
		.cdb_data(cdb_data)
	);

endmodule : alu_cluster

`default_nettype wire

/* tests/alu_cluster_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module alu_cluster_tb
	import lc3b_rs_pkg::*;
();

	typedef struct {
		string name;
		lc3b_word instr, vj, vk, exp_data, ext_data;
		rs_tag qj, qk, dest, ext_tag;
		logic no_wait, ext_en;
	} vec_t;

	logic clk = 1'b0;
	logic rst, flush, issue_valid, ext_valid;
	lc3b_word issue_instr, issue_vj, issue_vk, ext_data;
	rs_tag issue_qj, issue_qk, issue_dest, ext_tag;
	logic issue_ready, cdb_valid;
	rs_tag cdb_tag;
	lc3b_word cdb_data;

	// expected data per tag, pending until the tag is broadcast.
	lc3b_word sb_data [8];
	logic [7:0] sb_pending;
	vec_t vecs [10];
	string cur_name;
	int errors;
	int seed;

	alu_cluster alu_cluster_i (.*);

	initial begin
		forever #5 clk = ~clk;
	end

	task automatic check_word(input string name, input lc3b_word expected, actual);
		if (actual !== expected) begin
			$display("** Error %s: expected %h, actual %h", name, expected, actual);
			errors++;
		end
	endtask

	task automatic check_tag(input string name, input rs_tag expected, actual);
		if (actual !== expected) begin
			$display("** Error %s: expected tag %0d, actual tag %0d", name, expected, actual);
			errors++;
		end
	endtask

	task automatic check_flag(input string name, input logic expected, actual);
		if (actual !== expected) begin
			$display("** Error %s: expected %b, actual %b", name, expected, actual);
			errors++;
		end
	endtask

	task automatic end_run();
		$display("errors: %0d", errors);
		if (errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	endtask

	// next falling edge, scoring any CDB broadcast.
	task automatic step();
		@(negedge clk);
		if (cdb_valid && sb_pending[cdb_tag]) begin
			check_word(cur_name, sb_data[cdb_tag], cdb_data);
			sb_pending[cdb_tag] = 1'b0;
		end else if (cdb_valid) begin
			$display("%s: unexpected CDB broadcast for tag %0d", cur_name, cdb_tag);
			errors++;
		end
	endtask

	// idle waits for the scoreboard to drain, otherwise for a free station.
	task automatic wait_for(input logic idle);
		int cycles;
		cycles = 0;
		while ((idle ? (sb_pending != '0) : !issue_ready) && cycles < 40) begin
			step();
			cycles++;
		end
		if (idle ? (sb_pending != '0) : !issue_ready) begin
			$display("%s: timed out waiting, idle wait %b", cur_name, idle);
			errors++;
			end_run();
		end
	endtask

	task automatic clear_inputs();
		{flush, issue_valid, ext_valid} = '0;
		{issue_instr, issue_vj, issue_vk, issue_qj, issue_qk, issue_dest} = '0;
		{ext_tag, ext_data} = '0;
	endtask

	// an external result shows on the CDB one cycle after entry.
	task automatic send_ext(input rs_tag tag, input lc3b_word data);
		{ext_valid, ext_tag, ext_data} = {1'b1, tag, data};
		sb_data[tag] = data;
		sb_pending[tag] = 1'b1;
		step();
		clear_inputs();
		check_flag(cur_name, 1'b1, cdb_valid);
		check_tag(cur_name, tag, cdb_tag);
	endtask

	task automatic apply_vec(input vec_t v);
		cur_name = v.name;
		wait_for(1'b0);
		issue_valid = 1'b1;
		{issue_instr, issue_vj, issue_vk} = {v.instr, v.vj, v.vk};
		{issue_qj, issue_qk, issue_dest} = {v.qj, v.qk, v.dest};
		sb_data[v.dest] = v.exp_data;
		sb_pending[v.dest] = 1'b1;
		step();
		clear_inputs();
		if (v.ext_en)
			send_ext(v.ext_tag, v.ext_data);
		if (!v.no_wait)
			wait_for(1'b1);
	endtask

	function automatic vec_t row(input string label, input lc3b_word ins, a, b,
			input rs_tag tj, tk, d, input lc3b_word res, input logic nw);
		row = '{name: label, instr: ins, vj: a, vk: b, qj: tj, qk: tk, dest: d,
			exp_data: res, no_wait: nw, ext_en: 1'b0, ext_tag: 3'd0, ext_data: 16'h0000};
	endfunction

	// reference ALU from the LC-3b encoding, shift kind in bits 5 and 4.
	function automatic lc3b_word model(input lc3b_word ins, input lc3b_word a, b);
		lc3b_word fill;
		fill = a[15] ? ~(16'hffff >> b[3:0]) : 16'h0000;
		case (ins[15:12])
			4'h1: return a + b;
			4'h5: return a & b;
			4'h9: return ~a;
			4'hd: return ins[4] ? (a >> b[3:0]) | (ins[5] ? fill : 16'h0000) : a << b[3:0];
			default: return a;
		endcase
	endfunction

	initial begin
		lc3b_word ops [6];
		lc3b_word a, b, op;
		ops = '{16'h1000, 16'h5000, 16'h903f, 16'hd000, 16'hd010, 16'hd030};
		seed = 32'h76d3_23ab;
		errors = 0;
		sb_pending = '0;
		clear_inputs();
		rst = 1'b1;
		repeat (5)
			@(negedge clk);
		rst = 1'b0;
		cur_name = "reset";
		check_flag(cur_name, 1'b0, cdb_valid);
		check_flag(cur_name, 1'b1, issue_ready);

		// name, instr, vj, vk, qj, qk, dest, expected, no_wait.
		vecs = '{
			row("add", 16'h1000, 16'h1234, 16'h0ff1, 3'd0, 3'd0, 3'd1, 16'h2225, 1'b0),
			row("and", 16'h5000, 16'hf0f0, 16'h3c3c, 3'd0, 3'd0, 3'd2, 16'h3030, 1'b0),
			row("not", 16'h903f, 16'h00ff, 16'h0000, 3'd0, 3'd0, 3'd3, 16'hff00, 1'b0),
			row("sll", 16'hd000, 16'h0081, 16'h0004, 3'd0, 3'd0, 3'd4, 16'h0810, 1'b0),
			row("srl", 16'hd010, 16'h8000, 16'h0003, 3'd0, 3'd0, 3'd5, 16'h1000, 1'b0),
			row("sra", 16'hd030, 16'h8000, 16'h0003, 3'd0, 3'd0, 3'd6, 16'hf000, 1'b0),
			row("ext_wake", 16'h1000, 16'h0000, 16'h0003, 3'd7, 3'd0, 3'd1, 16'h0103, 1'b0),
			row("chain_a", 16'h1000, 16'h0003, 16'h0004, 3'd0, 3'd0, 3'd2, 16'h0007, 1'b1),
			row("chain_b", 16'hd000, 16'h0000, 16'h0002, 3'd2, 3'd0, 3'd3, 16'h001c, 1'b1),
			row("chain_c", 16'h903f, 16'h0000, 16'h0000, 3'd3, 3'd0, 3'd4, 16'hffe3, 1'b0)
		};
		// the load result that ext_wake depends on.
		{vecs[6].ext_en, vecs[6].ext_tag, vecs[6].ext_data} = {1'b1, 3'd7, 16'h0100};
		foreach (vecs[i])
			apply_vec(vecs[i]);

		// random operands, issued back to back.
		for (int i = 0; i < 6; i++) begin
			a = lc3b_word'($random(seed));
			b = lc3b_word'($random(seed));
			op = ops[$unsigned($random(seed)) % 6];
			apply_vec(row("random", op, a, b, 3'd0, 3'd0, rs_tag'(i + 1),
				model(op, a, b), i < 5));
		end

		// three stations wait on tag 5, so a fourth strobe is dropped.
		for (int i = 0; i < 3; i++)
			apply_vec(row("blocked", 16'h1000, 16'h0000, lc3b_word'(i), 3'd5, 3'd0,
				rs_tag'(i + 1), lc3b_word'(16'h0200 + i), 1'b1));
		check_flag(cur_name, 1'b0, issue_ready);
		{issue_valid, issue_instr, issue_dest} = {1'b1, 16'h1000, 3'd4};
		step();
		clear_inputs();
		send_ext(3'd5, 16'h0200);
		wait_for(1'b1);

		// flushed stations never broadcast, even once their tag arrives.
		for (int i = 0; i < 3; i++)
			apply_vec(row("flush", 16'h5000, 16'h0000, 16'hffff, 3'd6, 3'd0,
				rs_tag'(i + 1), 16'h0000, 1'b1));
		check_flag(cur_name, 1'b0, issue_ready);
		flush = 1'b1;
		step();
		clear_inputs();
		sb_pending = '0;
		check_flag(cur_name, 1'b1, issue_ready);
		send_ext(3'd6, 16'h0042);
		repeat (6)
			step();
		end_run();
	end

endmodule : alu_cluster_tb

`default_nettype wire

/* compile.f */
logic/lc3b_rs_pkg.sv
logic/alu_decode.sv
logic/alu.sv
logic/alu_res_station.sv
logic/rs_scheduler.sv
logic/alu_cluster.sv
tests/alu_cluster_tb.sv

/* Bender.yml */
package:
  name: alu_cluster

sources:
  - logic/lc3b_rs_pkg.sv
  - logic/alu_decode.sv
  - logic/alu.sv
  - logic/alu_res_station.sv
  - logic/rs_scheduler.sv
  - logic/alu_cluster.sv
  - target: test
    files:
      - tests/alu_cluster_tb.sv
